//--- compile.f
+incdir+verilog
verilog/decodePkg.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/immExtender.sv
verilog/destParser.sv
verilog/decodeStage.sv
verification/clockGen.sv
verification/tbDecode.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Iverilog
TOP      = tbDecode
FILELIST = compile.f
BUILD    = obj_dir

.PHONY: all build lint clean

all: build
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

lint:
	$(TOOL) --lint-only --timing -Iverilog --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

//--- verification/decode_stimulus.txt
# instr pc wrEn wrSel wrData | expected ctrl r1 r2 imm5 imm8 imm11 slbi destReg destValid
# ctrl = immSrc..regWrt in bits 20:12, brType 11:9, oper 8:6, bSrc 5:4, regDst 3:2, regSrc 1:0
D94C 0100 1 1 1234 0310A 1234 0000 000C 004C 014C 344C 3 1
D951 0102 1 2 00F0 1710A 1234 00F0 FFF1 0051 0151 3451 4 1
DA36 0104 0 0 0000 031CA 00F0 1234 FFF6 0036 0236 F036 5 1
D95B 0106 0 0 0000 0B14A 1234 00F0 FFFB 005B 015B 345B 6 1
D15D 0108 0 0 0000 0304A 1234 00F0 FFFD 005D 015D 345D 7 1
4170 010A 0 0 0000 03112 1234 0000 FFF0 0070 0170 3470 3 1
4A9F 010C 0 0 0000 17112 00F0 0000 FFFF FF9F 029F F09F 4 1
51B5 010E 0 0 0000 031D2 1234 0000 0015 00B5 01B5 34B5 5 1
5AD8 0110 0 0 0000 0B152 00F0 0000 0018 00D8 02D8 F0D8 6 1
8144 0112 0 0 0000 62116 1234 00F0 0004 0044 0144 3444 0 0
8AE2 0114 0 0 0000 23111 00F0 0000 0002 FFE2 02E2 F0E2 7 1
997E 0116 0 0 0000 63116 1234 0000 FFFE 007E 017E 347E 1 1
6280 0118 0 0 0000 02922 00F0 0000 0000 FF80 0280 F080 0 0
7105 011A 0 0 0000 02D22 1234 0000 0005 0005 0105 3405 0 0
2401 011C 0 0 0000 102122 0000 0000 0001 0001 FC01 0001 0 0
3010 011E 0 0 0000 10312C 0000 0000 FFF0 0010 0010 0010 7 1
2908 0120 0 0 0000 82122 1234 0000 0008 0008 0108 3408 0 0
3AFC 0122 0 0 0000 8312C 00F0 0000 FFFC FFFC 02FC F0FC 7 1
C39A 0124 0 0 0000 03127 0000 0000 FFFA FF9A 039A 009A 3 1
9155 0126 1 1 ABCD 03137 ABCD 00F0 FFF5 0055 0155 CD55 1 1
C908 0128 0 0 0000 0312A ABCD 0000 0008 0008 0108 CD08 2 1
E94C 012A 0 0 0000 0F10A ABCD 00F0 000C 004C 014C CD4C 3 1
FA30 012C 0 0 0000 0110A 00F0 ABCD FFF0 0030 0230 F030 4 1
A1A3 012E 0 0 0000 03012 ABCD 0000 0003 FFA3 01A3 CDA3 5 1
0800 0130 0 0 0000 00000 0000 0000 0000 0000 0000 0000 0 0
0000 0132 0 0 0000 00000 0000 0000 0000 0000 0000 0000 0 0

//--- verification/tbDecode.sv
module tbDecode
   import decodePkg::*;
;

   // Stimulus columns
   localparam int colInstr   = 0;
   localparam int colPc      = 1;
   localparam int colWrEn    = 2;
   localparam int colWrSel   = 3;
   localparam int colWrData  = 4;
   localparam int colCtrl    = 5;
   localparam int colR1      = 6;
   localparam int colR2      = 7;
   localparam int colImm5    = 8;
   localparam int colImm8    = 9;
   localparam int colImm11   = 10;
   localparam int colSlbi    = 11;
   localparam int colDest    = 12;
   localparam int colValid   = 13;
   localparam int numCols    = 14;
   localparam int maxLines   = 64;

   logic     clk;
   logic     rstN;
   wordT     instrIn;
   wordT     pcIn;
   regWriteT regWrite;
   idExT     idEx;

   logic [31:0] stim [maxLines][numCols];
   int          numLines;
   int          errors;
   int          checks;
   int          cycles;
   int          cycleLimit;

   clockGen u_clockGen (
      .clk  (clk),
      .rstN (rstN)
   );

   decodeStage u_decodeStage (
      .clk      (clk),
      .rstN     (rstN),
      .instrIn  (instrIn),
      .pcIn     (pcIn),
      .regWrite (regWrite),
      .idEx     (idEx)
   );

   //////////////////////////////
   // Helpers
   //////////////////////////////
   task automatic checkValue(input string name, input logic [191:0] got,
                             input logic [191:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // Lines starting with # are comments
   task automatic loadStimulus();
      int          fd;
      int          n;
      string       line;
      logic [31:0] v [numCols];
      fd = $fopen("verification/decode_stimulus.txt", "r");
      numLines = 0;
      if (fd == 0) begin
         $display("Could not open the stimulus file");
         errors++;
      end else begin
         while (!$feof(fd) && numLines < maxLines) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                           v[7], v[8], v[9], v[10], v[11], v[12], v[13]);
               if (n == numCols) begin
                  for (int c = 0; c < numCols; c++) begin
                     stim[numLines][c] = v[c];
                  end
                  numLines++;
               end else begin
                  $display("Stimulus line has the wrong number of columns");
                  errors++;
               end
            end
         end
         $fclose(fd);
      end
      if (numLines == 0) begin
         $display("No stimulus lines were read");
         errors++;
      end
   endtask

   task automatic driveLine(input int i);
      instrIn       = stim[i][colInstr][15:0];
      pcIn          = stim[i][colPc][15:0];
      regWrite.en   = stim[i][colWrEn][0];
      regWrite.sel  = stim[i][colWrSel][2:0];
      regWrite.data = stim[i][colWrData][15:0];
   endtask

   // idEx holds line i one edge after it was driven
   task automatic checkLine(input int i);
      checkValue("idEx.instr", idEx.instr, stim[i][colInstr][15:0]);
      checkValue("idEx.pc", idEx.pc, stim[i][colPc][15:0]);
      checkValue("idEx.ctrl", idEx.ctrl, stim[i][colCtrl][20:0]);
      checkValue("idEx.r1", idEx.r1, stim[i][colR1][15:0]);
      checkValue("idEx.r2", idEx.r2, stim[i][colR2][15:0]);
      checkValue("idEx.imm5", idEx.imm5, stim[i][colImm5][15:0]);
      checkValue("idEx.imm8", idEx.imm8, stim[i][colImm8][15:0]);
      checkValue("idEx.imm11", idEx.imm11, stim[i][colImm11][15:0]);
      checkValue("idEx.slbi", idEx.slbi, stim[i][colSlbi][15:0]);
      checkValue("idEx.destReg", idEx.destReg, stim[i][colDest][2:0]);
      checkValue("idEx.destValid", idEx.destValid, stim[i][colValid][0]);
   endtask

   //////////////////////////////
   // Run limit
   //////////////////////////////
   always @(posedge clk) begin
      cycles++;
      if (cycleLimit > 0 && cycles > cycleLimit) begin
         $display("Run stopped after %0d cycles without finishing", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial begin
      // Busy inputs through reset
      // STU raises every flag the clear must hide, R2 write must not land
      instrIn       = 16'h997E;
      pcIn          = 16'hFFFE;
      regWrite.en   = 1'b1;
      regWrite.sel  = 3'd2;
      regWrite.data = 16'hFFFF;
      errors     = 0;
      checks     = 0;
      cycles     = 0;
      cycleLimit = 0;
      loadStimulus();
      cycleLimit = numLines + 20;

      // Released on a falling edge
      @(posedge rstN);
      checkValue("idEx", idEx, '0);
      checkValue("idEx.ctrl.regWrt", idEx.ctrl.regWrt, 1'b0);
      checkValue("idEx.ctrl.memWrt", idEx.ctrl.memWrt, 1'b0);
      checkValue("idEx.ctrl.memEn", idEx.ctrl.memEn, 1'b0);
      checkValue("idEx.destValid", idEx.destValid, 1'b0);
      regWrite = '0;

      for (int i = 0; i < numLines; i++) begin
         driveLine(i);
         @(negedge clk);
         checkLine(i);
      end
      regWrite = '0;

      $display("Checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- verification/clockGen.sv
module clockGen (
   output logic clk,
   output logic rstN
);

   // 8 unit period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Reset held for two rising edges, released on a falling edge
   initial begin
      rstN = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
   end

endmodule

//--- verilog/decodeStage.sv
module decodeStage
   import decodePkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  wordT     instrIn,
   input  wordT     pcIn,
   input  regWriteT regWrite,
   output idExT     idEx
);

   decodeCtrlT ctrl;
   wordT       r1;
   wordT       r2;
   wordT       imm5;
   wordT       imm8;
   wordT       imm11;
   wordT       slbi;
   regSelT     destReg;
   logic       destValid;
   idExT       idExNext;

   //////////////////////////////
   // Decode blocks
   //////////////////////////////
   controlDecoder u_controlDecoder (
      .opcode (instrIn[15:11]),
      .func   (instrIn[1:0]),
      .ctrl   (ctrl)
   );

   // Rs in bits 10:8, Rt in bits 7:5
   regFile u_regFile (
      .clk       (clk),
      .rstN      (rstN),
      .read1Sel  (instrIn[10:8]),
      .read2Sel  (instrIn[7:5]),
      .regWrite  (regWrite),
      .read1Data (r1),
      .read2Data (r2)
   );

   immExtender u_immExtender (
      .instr (instrIn),
      .r1    (r1),
      .imm5  (imm5),
      .imm8  (imm8),
      .imm11 (imm11),
      .slbi  (slbi)
   );

   // Feeds the hazard unit downstream
   destParser u_destParser (
      .instr     (instrIn),
      .destReg   (destReg),
      .destValid (destValid)
   );

   //////////////////////////////
   // ID/EX register
   //////////////////////////////
   always_comb begin
      idExNext.instr     = instrIn;
      idExNext.pc        = pcIn;
      idExNext.ctrl      = ctrl;
      idExNext.r1        = r1;
      idExNext.r2        = r2;
      idExNext.imm5      = imm5;
      idExNext.imm8      = imm8;
      idExNext.imm11     = imm11;
      idExNext.slbi      = slbi;
      idExNext.destReg   = destReg;
      idExNext.destValid = destValid;
   end

   // One instruction in, one out, every cycle
   always_ff @(posedge clk) begin
      if (!rstN) begin
         idEx <= '0;
      end else begin
         idEx <= idExNext;
      end
   end

   // Only STU both stores and writes back, into its base register
   aStoreWrites: assert property (@(posedge clk) disable iff (!rstN)
      (idEx.ctrl.memWrt && idEx.ctrl.regWrt)
         |-> ((idEx.instr[15:11] == opStu) && (idEx.destReg == idEx.instr[10:8])))
      else $error("memWrt with regWrt on opcode %b", idEx.instr[15:11]);

   // Hazard view agrees with the decoder writeback
   aDestMatch: assert property (@(posedge clk) disable iff (!rstN)
      idEx.destValid == idEx.ctrl.regWrt)
      else $error("destValid and regWrt differ on opcode %b", idEx.instr[15:11]);

endmodule

//--- verilog/destParser.sv
`include "decode_cfg.svh"

module destParser
   import decodePkg::*;
(
   input  wordT   instr,
   output regSelT destReg,
   output logic   destValid
);

   opcodeT opcode;

   assign opcode = instr[15:11];

   // Destination for the RAW check
   // nothing valid for stores, branches, J, JR and system ops
   always_comb begin
      destReg   = '0;
      destValid = 1'b0;
      case (opcode)
         // R-format, Rd in bits 4:2
         opShiftR, opArithR, opBtr, opSeq, opSlt, opSle, opSco: begin
            destReg   = instr[4:2];
            destValid = 1'b1;
         end
         // I-format, Rd in bits 7:5
         opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli, opLd: begin
            destReg   = instr[7:5];
            destValid = 1'b1;
         end
         // Rs field, STU updates its base register
         opLbi, opSlbi, opStu: begin
            destReg   = instr[10:8];
            destValid = 1'b1;
         end
         opJal, opJalr: begin
            destReg   = regSelT'(`LINK_REG);
            destValid = 1'b1;
         end
         default: begin
            destValid = 1'b0;
         end
      endcase
   end

endmodule

//--- verilog/immExtender.sv
module immExtender
   import decodePkg::*;
(
   input  wordT instr,
   input  wordT r1,
   output wordT imm5,
   output wordT imm8,
   output wordT imm11,
   output wordT slbi
);

   logic zeroExt;

   // Logical immediates, XORI and ANDNI
   assign zeroExt = (instr[15:11] == opXori) || (instr[15:11] == opAndni);

   // I-format field, bits 4:0
   assign imm5 = zeroExt ? wordT'(instr[4:0])
                         : wordT'(signed'(instr[4:0]));

   // LBI, branches, JR and JALR
   assign imm8 = zeroExt ? wordT'(instr[7:0])
                         : wordT'(signed'(instr[7:0]));

   // J and JAL displacement
   // always signed
   assign imm11 = wordT'(signed'(instr[10:0]));

   // Shift Rs left a byte, fill with the immediate
   assign slbi = {r1[7:0], instr[7:0]};

endmodule

//--- verilog/regFile.sv
`include "decode_cfg.svh"

module regFile
   import decodePkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  regSelT   read1Sel,
   input  regSelT   read2Sel,
   input  regWriteT regWrite,
   output wordT     read1Data,
   output wordT     read2Data
);

   wordT regs [`NUM_REGS];

   logic hit1;
   logic hit2;

   //////////////////////////////
   // Storage
   //////////////////////////////
   // R0 is an ordinary register here
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (regWrite.en) begin
         regs[regWrite.sel] <= regWrite.data;
      end
   end

   //////////////////////////////
   // Reads
   //////////////////////////////
   // Same-cycle writeback to the read register
   assign hit1 = regWrite.en && (regWrite.sel == read1Sel);
   assign hit2 = regWrite.en && (regWrite.sel == read2Sel);

   // Bypass so decode sees the value landing this edge
   assign read1Data = hit1 ? regWrite.data : regs[read1Sel];
   assign read2Data = hit2 ? regWrite.data : regs[read2Sel];

   // Writeback must name a real register
   aWrSelKnown: assert property (@(posedge clk) disable iff (!rstN)
      regWrite.en |-> !$isunknown(regWrite.sel))
      else $error("regFile write with unknown select");

endmodule

//--- verilog/controlDecoder.sv
module controlDecoder
   import decodePkg::*;
(
   input  opcodeT     opcode,
   input  logic [1:0] func,
   output decodeCtrlT ctrl
);

   // Opcode classes
   logic isHaltNop;
   logic isSys;
   logic isBranch;
   logic isAluImm;
   logic isShiftImm;
   logic isMemOp;
   logic isAluReg;
   logic isCompare;
   logic isCmpSub;
   logic isLinkJump;

   // HALT and NOP
   assign isHaltNop  = (opcode[4:1] == 4'b0000);
   // siic and RTI
   assign isSys      = (opcode[4:1] == 4'b0001);
   assign isBranch   = (opcode[4:2] == 3'b011);
   assign isAluImm   = (opcode[4:2] == 3'b010);
   assign isShiftImm = (opcode[4:2] == 3'b101);
   // ST, LD, SLBI and STU share this prefix
   assign isMemOp    = (opcode[4:2] == 3'b100);
   assign isAluReg   = (opcode == opShiftR) || (opcode == opArithR);
   assign isCompare  = (opcode[4:2] == 3'b111);
   // SCO only adds, it wants the carry out
   assign isCmpSub   = isCompare && (opcode != opSco);
   assign isLinkJump = (opcode == opJal) || (opcode == opJalr);

   // Low bits select ADD, SUB, XOR or ANDN
   // SUB reuses the adder with an inverted operand
   function automatic aluOperT arithOper(input logic [1:0] sel);
      case (sel)
         2'b10:   arithOper = aluXor;
         2'b11:   arithOper = aluAnd;
         default: arithOper = aluAdd;
      endcase
   endfunction

   always_comb begin
      ctrl = '0;

      //////////////////////////////
      // PC control
      //////////////////////////////
      // J and JAL, PC plus imm11
      ctrl.immSrc  = ({opcode[4:2], opcode[0]} == 4'b0010);
      // JR and JALR, target from ALU as Rs plus imm8
      ctrl.aluJump = ({opcode[4:2], opcode[0]} == 4'b0011);

      //////////////////////////////
      // Memory control
      //////////////////////////////
      // ST and STU have equal low opcode bits
      ctrl.memWrt = isMemOp && (opcode[1] == opcode[0]);
      // SLBI sits in this block but never reaches memory
      ctrl.memEn  = isMemOp && (opcode != opSlbi);

      //////////////////////////////
      // Writeback control
      //////////////////////////////
      ctrl.regWrt = !(isBranch || isHaltNop || isSys || (opcode == opJ)
                      || (opcode == opJr) || (opcode == opSt));

      if (isLinkJump) begin
         ctrl.regDst = 2'b11;
      end else if (opcode[4:3] == 2'b11 && opcode != opLbi) begin
         // R-format, BTR and compares write Rd in bits 4:2
         ctrl.regDst = 2'b10;
      end else if ((opcode == opLbi) || (opcode == opSlbi) || (opcode == opStu)
                   || (opcode == opSt)) begin
         ctrl.regDst = 2'b01;
      end else begin
         ctrl.regDst = 2'b00;
      end

      // LBI and SLBI take the B operand straight through
      if ((opcode == opLbi) || (opcode == opSlbi)) begin
         ctrl.regSrc = 2'b11;
      end else if (opcode == opLd) begin
         ctrl.regSrc = 2'b01;
      end else if (isHaltNop || isLinkJump) begin
         // Return address from the PC adder
         ctrl.regSrc = 2'b00;
      end else begin
         ctrl.regSrc = 2'b10;
      end

      //////////////////////////////
      // ALU control
      //////////////////////////////
      if (isHaltNop) begin
         // Idle ALU
         ctrl.oper = 3'b000;
      end else if (opcode == opArithR) begin
         ctrl.oper = arithOper(func);
      end else if (opcode == opShiftR) begin
         ctrl.oper = {1'b0, func};
      end else if (isShiftImm) begin
         ctrl.oper = {1'b0, opcode[1:0]};
      end else if (isAluImm) begin
         ctrl.oper = arithOper(opcode[1:0]);
      end else begin
         // Address math, branches and compares all add
         ctrl.oper = aluAdd;
      end

      // SUB and SUBI compute Rt - Rs
      ctrl.invA = ((opcode == opArithR) && (func == 2'b01)) || (opcode == opSubi);
      // ANDN, ANDNI, and Rs - Rt for compares
      ctrl.invB = ((opcode == opArithR) && (func == 2'b11)) || (opcode == opAndni)
                  || isCmpSub;
      // Plus one only when subtracting, AND ignores it
      ctrl.cin  = ctrl.invA || isCmpSub;

      if (isAluReg || isCompare || isHaltNop) begin
         ctrl.bSrc = 2'b00;
      end else if (isAluImm || isShiftImm || (isMemOp && (opcode != opSlbi))) begin
         ctrl.bSrc = 2'b01;
      end else if (opcode == opSlbi) begin
         ctrl.bSrc = 2'b11;
      end else begin
         ctrl.bSrc = 2'b10;
      end

      ctrl.brType = isBranch ? {1'b1, opcode[1:0]} : 3'b000;
      // Signed overflow matters everywhere but SCO
      ctrl.sign   = (opcode != opSco) && !isHaltNop;
   end

   // Decoder consistency
   always_comb begin
      // A store needs the memory enabled
      aMemWrtEn: assert final (!ctrl.memWrt || ctrl.memEn)
         else $error("memWrt without memEn for opcode %b", opcode);
      // One PC source at most
      aPcSrcOne: assert final (!(ctrl.immSrc && ctrl.aluJump))
         else $error("immSrc and aluJump both set for opcode %b", opcode);
   end

endmodule

//--- verilog/decodePkg.sv
`include "decode_cfg.svh"

package decodePkg;

   //////////////////////////////
   // Vector types
   //////////////////////////////
   typedef logic [`DATA_WIDTH-1:0] wordT;
   typedef logic [2:0] regSelT;
   typedef logic [4:0] opcodeT;
   typedef logic [2:0] aluOperT;
   // Top bit marks a branch, low bits the condition
   typedef logic [2:0] brTypeT;
   typedef logic [1:0] twoSelT;

   //////////////////////////////
   // Opcodes
   //////////////////////////////
   localparam opcodeT opJ      = 5'b00100;
   localparam opcodeT opJr     = 5'b00101;
   localparam opcodeT opJal    = 5'b00110;
   localparam opcodeT opJalr   = 5'b00111;
   localparam opcodeT opAddi   = 5'b01000;
   localparam opcodeT opSubi   = 5'b01001;
   localparam opcodeT opXori   = 5'b01010;
   localparam opcodeT opAndni  = 5'b01011;
   localparam opcodeT opSt     = 5'b10000;
   localparam opcodeT opLd     = 5'b10001;
   localparam opcodeT opSlbi   = 5'b10010;
   localparam opcodeT opStu    = 5'b10011;
   localparam opcodeT opRoli   = 5'b10100;
   localparam opcodeT opSlli   = 5'b10101;
   localparam opcodeT opRori   = 5'b10110;
   localparam opcodeT opSrli   = 5'b10111;
   localparam opcodeT opLbi    = 5'b11000;
   localparam opcodeT opBtr    = 5'b11001;
   // Register-register shifts, func picks the kind
   localparam opcodeT opShiftR = 5'b11010;
   // ADD, SUB, XOR, ANDN by func
   localparam opcodeT opArithR = 5'b11011;
   localparam opcodeT opSeq    = 5'b11100;
   localparam opcodeT opSlt    = 5'b11101;
   localparam opcodeT opSle    = 5'b11110;
   localparam opcodeT opSco    = 5'b11111;

   // ALU operations, shifts occupy 000 to 011
   localparam aluOperT aluAdd = 3'b100;
   localparam aluOperT aluAnd = 3'b101;
   localparam aluOperT aluXor = 3'b111;

   //////////////////////////////
   // Bundles
   //////////////////////////////
   typedef struct packed {
      logic    immSrc;
      logic    aluJump;
      logic    memWrt;
      logic    memEn;
      logic    invA;
      logic    invB;
      logic    cin;
      logic    sign;
      logic    regWrt;
      brTypeT  brType;
      aluOperT oper;
      // 00 Rt, 01 imm5, 10 imm8, 11 slbi
      twoSelT  bSrc;
      // 00 bits 7:5, 01 bits 10:8, 10 bits 4:2, 11 link
      twoSelT  regDst;
      // 00 PC adder, 01 memory, 10 ALU, 11 B operand
      twoSelT  regSrc;
   } decodeCtrlT;

   // Writeback port into the register file
   typedef struct packed {
      logic   en;
      regSelT sel;
      wordT   data;
   } regWriteT;

   typedef struct packed {
      wordT       instr;
      wordT       pc;
      decodeCtrlT ctrl;
      wordT       r1;
      wordT       r2;
      wordT       imm5;
      wordT       imm8;
      wordT       imm11;
      wordT       slbi;
      regSelT     destReg;
      logic       destValid;
   } idExT;

endpackage

//--- verilog/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Datapath word
// PC shares this width
`define DATA_WIDTH 16

// Architectural registers
// ISA select fields stay 3 bits wide
`define NUM_REGS 8

// Return address target of JAL and JALR
`define LINK_REG 7

`endif
